// ==== src/vidGenPkg.sv ====
package vidGenPkg;

    // counter widths for 640x400 timing
    localparam int hCountW = 10;
    localparam int vCountW = 9;

    // each VRAM chip is 32 KiB
    localparam int vramAddrW = 15;

    // control/status register sits at the top of the cpu window
    localparam logic [15:0] regAddr = 16'hFFFF;

    // returned for cpu vram reads, which are acknowledged but not served
    localparam logic [7:0] vramReadFill = 8'hFF;

    // blanking flags in the register read byte
    localparam int statHBlankBit = 4;
    localparam int statVBlankBit = 5;

    // registered scan position shared by all blocks
    typedef struct packed {
        logic [hCountW-1:0] hCount;
        logic [vCountW-1:0] vCount;
        logic               hActive;
        logic               vActive;
        // high on the first pixel of every visible 4-pixel group
        logic               fetchSlot;
    } scanPos_t;

    // same bit layout as the cpu data byte
    typedef struct packed {
        logic [1:0] mode;
        logic       bufSel;
        logic       blank;
    } vidCtrl_t;

    // one cpu write into vram, addr[15] picks the chip
    typedef struct packed {
        logic        valid;
        logic [15:0] addr;
        logic [7:0]  data;
    } vramWrReq_t;

    // all vram pins, strobes active low
    typedef struct packed {
        logic                 nCe0;
        logic                 nCe1;
        logic                 nRd;
        logic                 nWr;
        logic [vramAddrW-1:0] addr;
        logic [7:0]           dataOut;
        logic                 dataOe;
    } vramBus_t;

endpackage

// ==== src/scanTimer.sv ====
`timescale 1ns/1ps

module scanTimer #(
    parameter int hVis   = 640,
    parameter int hFront = 16,
    parameter int hSync  = 96,
    parameter int hBack  = 48,
    parameter int vVis   = 400,
    parameter int vFront = 12,
    parameter int vSync  = 2,
    parameter int vBack  = 35
) (
    input  logic                pixClk,
    input  logic                nReset,
    output vidGenPkg::scanPos_t scanPos
);
    import vidGenPkg::*;

    localparam int hTotal = hVis + hFront + hSync + hBack;
    localparam int vTotal = vVis + vFront + vSync + vBack;

    logic [hCountW-1:0] hNext;
    logic [vCountW-1:0] vNext;
    logic               lineEnd;
    logic               hActNext;
    logic               vActNext;

    // flags follow the next position so they line up with the counters
    always_comb begin
        lineEnd = (int'(scanPos.hCount) == hTotal - 1);
        hNext = lineEnd ? '0 : scanPos.hCount + 1'b1;
        if (!lineEnd) begin
            vNext = scanPos.vCount;
        end else if (int'(scanPos.vCount) == vTotal - 1) begin
            vNext = '0;
        end else begin
            vNext = scanPos.vCount + 1'b1;
        end
        hActNext = (int'(hNext) < hVis);
        vActNext = (int'(vNext) < vVis);
    end

    always_ff @(posedge pixClk or negedge nReset) begin
        if (!nReset) begin
            // position 0,0 is visible and starts a fetch group
            scanPos.hCount    <= '0;
            scanPos.vCount    <= '0;
            scanPos.hActive   <= 1'b1;
            scanPos.vActive   <= 1'b1;
            scanPos.fetchSlot <= 1'b1;
        end else begin
            scanPos.hCount    <= hNext;
            scanPos.vCount    <= vNext;
            scanPos.hActive   <= hActNext;
            scanPos.vActive   <= vActNext;
            scanPos.fetchSlot <= hActNext && vActNext && (hNext[1:0] == 2'b00);
        end
    end

    // counter never leaves the line
    hRange: assert property (@(posedge pixClk) disable iff (!nReset)
        int'(scanPos.hCount) < hTotal)
        else $error("hCount %0d out of range", scanPos.hCount);

endmodule

// ==== src/cpuBusFsm.sv ====
`timescale 1ns/1ps

module cpuBusFsm (
    input  logic                  pixClk,
    input  logic                  nReset,
    input  logic                  nCpuCE,
    input  logic                  nCpuDS,
    input  logic                  cpuRnW,
    input  logic [15:0]           cpuAddr,
    input  logic [7:0]            cpuDataIn,
    input  vidGenPkg::scanPos_t   scanPos,
    output logic                  nCpuDSACK,
    output logic [7:0]            cpuDataOut,
    output logic                  cpuDataOe,
    output vidGenPkg::vidCtrl_t   vidCtrl,
    output vidGenPkg::vramWrReq_t wrReq
);
    import vidGenPkg::*;

    typedef enum logic [1:0] {
        idle,
        acknowledge,
        waitRelease
    } busState_t;

    busState_t  state;
    logic       cpuReq;
    logic       serve;
    logic       regHit;
    logic [7:0] statusByte;

    always_comb begin
        cpuReq = !nCpuCE && !nCpuDS;
        regHit = (cpuAddr == regAddr);
        // fetch slots belong to the display, so the request waits one cycle
        serve = (state == idle) && cpuReq && !scanPos.fetchSlot;
    end

    // status read shows the control bits and blanking flags with the top bits tied high
    always_comb begin
        statusByte = {2'b11, 2'b00, vidCtrl};
        statusByte[statHBlankBit] = !scanPos.hActive;
        statusByte[statVBlankBit] = !scanPos.vActive;
    end

    // write request goes out in the serving cycle
    // so it lands on the pins before the next fetch slot
    always_comb begin
        wrReq.valid = serve && !regHit && !cpuRnW;
        wrReq.addr  = cpuAddr;
        wrReq.data  = cpuDataIn;
    end

    always_ff @(posedge pixClk or negedge nReset) begin
        if (!nReset) begin
            state     <= idle;
            nCpuDSACK <= 1'b1;
            cpuDataOe <= 1'b0;
            vidCtrl   <= '0;
        end else begin
            // acknowledge and read drive are single-cycle by default
            nCpuDSACK <= 1'b1;
            cpuDataOe <= 1'b0;
            case (state)
                idle: begin
                    if (serve) begin
                        state     <= acknowledge;
                        nCpuDSACK <= 1'b0;
                        cpuDataOe <= cpuRnW;
                        if (regHit && !cpuRnW) begin
                            vidCtrl <= vidCtrl_t'(cpuDataIn[3:0]);
                        end
                    end
                end
                acknowledge: begin
                    state <= waitRelease;
                end
                waitRelease: begin
                    // hold off until the cpu ends its cycle
                    if (nCpuDS) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // read data is captured while serving and shown with the acknowledge
    always_ff @(posedge pixClk) begin
        if (serve) begin
            cpuDataOut <= regHit ? statusByte : vramReadFill;
        end
    end

    // acknowledge is a one-cycle pulse
    ackPulse: assert property (@(posedge pixClk) disable iff (!nReset)
        !nCpuDSACK |=> nCpuDSACK)
        else $error("nCpuDSACK held low");

endmodule

// ==== src/vramSequencer.sv ====
`timescale 1ns/1ps

module vramSequencer #(
    parameter int hVis = 640
) (
    input  logic                  pixClk,
    input  logic                  nReset,
    input  vidGenPkg::scanPos_t   scanPos,
    input  vidGenPkg::vidCtrl_t   vidCtrl,
    input  vidGenPkg::vramWrReq_t wrReq,
    input  logic [7:0]            vramDataIn,
    output vidGenPkg::vramBus_t   vramBus,
    output logic [7:0]            fetchByte
);
    import vidGenPkg::*;

    // one byte covers four columns
    localparam int bytesPerLine = hVis / 4;
    // linear address has one bit more than a chip and that bit picks the chip
    localparam int linW = vramAddrW + 1;

    localparam vramBus_t busIdle = '{
        nCe0:    1'b1,
        nCe1:    1'b1,
        nRd:     1'b1,
        nWr:     1'b1,
        addr:    '0,
        dataOut: '0,
        dataOe:  1'b0
    };

    logic [vCountW-1:0] dispLine;
    logic [linW-1:0]    linAddr;
    logic               dispChip;
    vramBus_t           busNext;

    // display address for the group starting at the current column
    always_comb begin
        // line doubling unless in the linear modes
        dispLine = vidCtrl.mode[0] ? scanPos.vCount : (scanPos.vCount >> 1);
        linAddr = linW'(dispLine) * linW'(bytesPerLine) + linW'(scanPos.hCount >> 2);
        // linear buffer runs over into chip 1 and otherwise bufSel flips buffers
        dispChip = vidCtrl.mode[0] ? linAddr[vramAddrW] : vidCtrl.bufSel;
    end

    always_comb begin
        busNext = busIdle;
        if (scanPos.fetchSlot) begin
            // display read with data latched at the end of the strobe cycle
            busNext.nCe0 = dispChip;
            busNext.nCe1 = !dispChip;
            busNext.nRd  = 1'b0;
            busNext.addr = linAddr[vramAddrW-1:0];
        end else if (wrReq.valid) begin
            busNext.nCe0    = wrReq.addr[15];
            busNext.nCe1    = !wrReq.addr[15];
            busNext.nWr     = 1'b0;
            busNext.addr    = wrReq.addr[vramAddrW-1:0];
            busNext.dataOut = wrReq.data;
            busNext.dataOe  = 1'b1;
        end
    end

    always_ff @(posedge pixClk or negedge nReset) begin
        if (!nReset) begin
            vramBus <= busIdle;
        end else begin
            vramBus <= busNext;
        end
    end

    // only display reads use nRd
    always_ff @(posedge pixClk) begin
        if (!vramBus.nRd) begin
            fetchByte <= vramDataIn;
        end
    end

    // never two chips on the bus
    chipExcl: assert property (@(posedge pixClk) disable iff (!nReset)
        vramBus.nCe0 || vramBus.nCe1)
        else $error("both vram chips enabled");

    // cpu writes stay out of the fetch cycles
    strobeExcl: assert property (@(posedge pixClk) disable iff (!nReset)
        vramBus.nRd || vramBus.nWr)
        else $error("vram read and write strobes together");

endmodule

// ==== src/pixelShifter.sv ====
`timescale 1ns/1ps

module pixelShifter #(
    parameter int hVis   = 640,
    parameter int hFront = 16,
    parameter int hSync  = 96,
    parameter int vVis   = 400,
    parameter int vFront = 12,
    parameter int vSync  = 2
) (
    input  logic                pixClk,
    input  logic                nReset,
    input  vidGenPkg::scanPos_t scanPos,
    input  vidGenPkg::vidCtrl_t vidCtrl,
    input  logic [7:0]          fetchByte,
    output logic [3:0]          vidOut,
    output logic                vidH,
    output logic                vidV
);
    import vidGenPkg::*;

    localparam int hSyncStart = hVis + hFront;
    localparam int hSyncEnd   = hSyncStart + hSync;
    localparam int vSyncStart = vVis + vFront;
    localparam int vSyncEnd   = vSyncStart + vSync;

    scanPos_t   posD1;
    scanPos_t   posD2;
    logic [1:0] col;
    logic [1:0] grayPair;
    logic [3:0] pixel;
    logic       hSyncOn;
    logic       vSyncOn;

    // two stages so the position lines up with fetchByte
    always_ff @(posedge pixClk or negedge nReset) begin
        if (!nReset) begin
            posD1 <= '0;
            posD2 <= '0;
        end else begin
            posD1 <= scanPos;
            posD2 <= posD1;
        end
    end

    always_comb begin
        col = posD2.hCount[1:0];
        // pair k sits at bits 7-2k and 6-2k
        grayPair = 2'(fetchByte >> {~col, 1'b0});
        if (!posD2.hActive || !posD2.vActive || vidCtrl.blank) begin
            pixel = '0;
        end else if (vidCtrl.mode[1]) begin
            // gray level, high bit drives rgb and low bit intensity
            pixel = {{3{grayPair[1]}}, grayPair[0]};
        end else begin
            // 4bpp with each nibble shown for two columns
            pixel = col[1] ? fetchByte[3:0] : fetchByte[7:4];
        end
        hSyncOn = (int'(posD2.hCount) >= hSyncStart) && (int'(posD2.hCount) < hSyncEnd);
        vSyncOn = (int'(posD2.vCount) >= vSyncStart) && (int'(posD2.vCount) < vSyncEnd);
    end

    // third delay stage, syncs and pixels leave together
    always_ff @(posedge pixClk or negedge nReset) begin
        if (!nReset) begin
            vidOut <= '0;
            vidH   <= 1'b1;
            vidV   <= 1'b0;
        end else begin
            vidOut <= pixel;
            // hsync negative, vsync positive
            vidH   <= !hSyncOn;
            vidV   <= vSyncOn;
        end
    end

endmodule

// ==== src/vidGen.sv ====
`timescale 1ns/1ps

module vidGen #(
    parameter int hVis   = 640,
    parameter int hFront = 16,
    parameter int hSync  = 96,
    parameter int hBack  = 48,
    parameter int vVis   = 400,
    parameter int vFront = 12,
    parameter int vSync  = 2,
    parameter int vBack  = 35
) (
    input  logic                              pixClk,
    input  logic                              nReset,
    input  logic                              nCpuCE,
    input  logic                              nCpuDS,
    input  logic                              cpuRnW,
    input  logic [15:0]                       cpuAddr,
    input  logic [7:0]                        cpuDataIn,
    input  logic [7:0]                        vramDataIn,
    output logic                              nCpuDSACK,
    output logic [7:0]                        cpuDataOut,
    output logic                              cpuDataOe,
    output logic                              nVramCE0,
    output logic                              nVramCE1,
    output logic                              nVramRd,
    output logic                              nVramWr,
    output logic [vidGenPkg::vramAddrW-1:0]   vramAddr,
    output logic [7:0]                        vramDataOut,
    output logic                              vramDataOe,
    output logic [3:0]                        vidOut,
    output logic                              vidH,
    output logic                              vidV
);
    import vidGenPkg::*;

    scanPos_t   scanPos;
    vidCtrl_t   vidCtrl;
    vramWrReq_t wrReq;
    vramBus_t   vramBus;
    logic [7:0] fetchByte;

    // pixel and line counters
    scanTimer #(
        .hVis(hVis), .hFront(hFront), .hSync(hSync), .hBack(hBack),
        .vVis(vVis), .vFront(vFront), .vSync(vSync), .vBack(vBack)
    ) scanTimer_i (
        .pixClk (pixClk),
        .nReset (nReset),
        .scanPos(scanPos)
    );

    // cpu side, register and write requests
    cpuBusFsm cpuBusFsm_i (
        .pixClk    (pixClk),
        .nReset    (nReset),
        .nCpuCE    (nCpuCE),
        .nCpuDS    (nCpuDS),
        .cpuRnW    (cpuRnW),
        .cpuAddr   (cpuAddr),
        .cpuDataIn (cpuDataIn),
        .scanPos   (scanPos),
        .nCpuDSACK (nCpuDSACK),
        .cpuDataOut(cpuDataOut),
        .cpuDataOe (cpuDataOe),
        .vidCtrl   (vidCtrl),
        .wrReq     (wrReq)
    );

    vramSequencer #(
        .hVis(hVis)
    ) vramSequencer_i (
        .pixClk    (pixClk),
        .nReset    (nReset),
        .scanPos   (scanPos),
        .vidCtrl   (vidCtrl),
        .wrReq     (wrReq),
        .vramDataIn(vramDataIn),
        .vramBus   (vramBus),
        .fetchByte (fetchByte)
    );

    pixelShifter #(
        .hVis(hVis), .hFront(hFront), .hSync(hSync),
        .vVis(vVis), .vFront(vFront), .vSync(vSync)
    ) pixelShifter_i (
        .pixClk   (pixClk),
        .nReset   (nReset),
        .scanPos  (scanPos),
        .vidCtrl  (vidCtrl),
        .fetchByte(fetchByte),
        .vidOut   (vidOut),
        .vidH     (vidH),
        .vidV     (vidV)
    );

    // vram pins straight from the registered bus group
    assign nVramCE0    = vramBus.nCe0;
    assign nVramCE1    = vramBus.nCe1;
    assign nVramRd     = vramBus.nRd;
    assign nVramWr     = vramBus.nWr;
    assign vramAddr    = vramBus.addr;
    assign vramDataOut = vramBus.dataOut;
    assign vramDataOe  = vramBus.dataOe;

endmodule

// ==== sim/vramModel.sv ====
`timescale 1ns/1ps

module vramModel (
    input  logic        pixClk,
    input  logic        nCe0,
    input  logic        nCe1,
    input  logic        nRd,
    input  logic        nWr,
    input  logic [14:0] addr,
    input  logic [7:0]  dataIn,
    input  logic        dataOe,
    output logic [7:0]  dataOut
);

    // two 32 KiB chips
    logic [7:0] mem0 [0:32767];
    logic [7:0] mem1 [0:32767];

    // power-up contents follow the full address, chip 1 differs from chip 0
    initial begin
        for (int a = 0; a < 32768; a++) begin
            mem0[a] = 8'(a) ^ 8'(a >> 8);
            mem1[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5A;
        end
    end

    // read is asynchronous while nRd is low
    always_comb begin
        if (!nRd && !nCe0) begin
            dataOut = mem0[addr];
        end else if (!nRd && !nCe1) begin
            dataOut = mem1[addr];
        end else begin
            dataOut = 8'hFF;
        end
    end

    // write takes effect at the clock edge ending the strobe cycle
    always @(posedge pixClk) begin
        if (!nWr && dataOe && !nCe0) begin
            mem0[addr] <= dataIn;
        end
        if (!nWr && dataOe && !nCe1) begin
            mem1[addr] <= dataIn;
        end
    end

endmodule

// ==== sim/vidGenTb.sv ====
`timescale 1ns/1ps

module vidGenTb;

    // reduced timing so a frame is 48 x 15 cycles
    localparam int hVis = 32;
    localparam int hFront = 4;
    localparam int hSync = 8;
    localparam int hBack = 4;
    localparam int vVis = 8;
    localparam int vFront = 2;
    localparam int vSync = 2;
    localparam int vBack = 3;
    localparam int hTotal = hVis + hFront + hSync + hBack;
    localparam int vTotal = vVis + vFront + vSync + vBack;
    localparam int maxCycles = 8 * hTotal * vTotal + 2000;
    localparam logic [15:0] ctrlAddr = 16'hFFFF;
    // acknowledge shows up at most three edges after the strobes go low
    localparam int ackLimit = 3;

    logic        pixClk = 1'b0;
    logic        nReset;
    logic        nCpuCE;
    logic        nCpuDS;
    logic        cpuRnW;
    logic [15:0] cpuAddr;
    logic [7:0]  cpuDataIn;
    logic [7:0]  vramDataIn;
    logic        nCpuDSACK;
    logic [7:0]  cpuDataOut;
    logic        cpuDataOe;
    logic        nVramCE0;
    logic        nVramCE1;
    logic        nVramRd;
    logic        nVramWr;
    logic [14:0] vramAddr;
    logic [7:0]  vramDataOut;
    logic        vramDataOe;
    logic [3:0]  vidOut;
    logic        vidH;
    logic        vidV;

    // golden copies of both chips and of the control register
    logic [7:0]  gold0 [0:32767];
    logic [7:0]  gold1 [0:32767];
    logic [3:0]  tbCtrl;
    logic [31:0] lfsrState;

    int   errCount;
    int   pixChecks;
    int   accessCount;
    int   ackCount;
    int   cycleCount;
    logic checkOn;

    // position of the pixel currently on vidOut
    int         posH;
    int         posV;
    logic       lockedV;
    logic [3:0] expPix;
    logic       hPrev;
    logic       vPrev;
    int         hLowLen;
    int         hPer;
    logic       hPerValid;
    int         vHighLen;
    int         vPer;
    logic       vPerValid;

    always #4 pixClk = !pixClk;

    vidGen #(
        .hVis(hVis), .hFront(hFront), .hSync(hSync), .hBack(hBack),
        .vVis(vVis), .vFront(vFront), .vSync(vSync), .vBack(vBack)
    ) vidGen_i (
        .pixClk(pixClk), .nReset(nReset), .nCpuCE(nCpuCE), .nCpuDS(nCpuDS),
        .cpuRnW(cpuRnW), .cpuAddr(cpuAddr), .cpuDataIn(cpuDataIn),
        .vramDataIn(vramDataIn), .nCpuDSACK(nCpuDSACK), .cpuDataOut(cpuDataOut),
        .cpuDataOe(cpuDataOe), .nVramCE0(nVramCE0), .nVramCE1(nVramCE1),
        .nVramRd(nVramRd), .nVramWr(nVramWr), .vramAddr(vramAddr),
        .vramDataOut(vramDataOut), .vramDataOe(vramDataOe), .vidOut(vidOut),
        .vidH(vidH), .vidV(vidV)
    );

    vramModel vramModel_i (
        .pixClk(pixClk), .nCe0(nVramCE0), .nCe1(nVramCE1), .nRd(nVramRd),
        .nWr(nVramWr), .addr(vramAddr), .dataIn(vramDataOut), .dataOe(vramDataOe),
        .dataOut(vramDataIn)
    );

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // power-up contents of a chip follow the same rule as the memory model
    function automatic logic [7:0] fillByte(input logic chip, input int a);
        return 8'(a) ^ 8'(a >> 8) ^ (chip ? 8'h5A : 8'h00);
    endfunction

    // expected pixel from the display address and pixel rules
    function automatic logic [3:0] pixelFor(input int h, input int v);
        int         line;
        int         lin;
        int         k;
        logic       chip;
        logic [7:0] b;
        logic [1:0] pair;
        if (h >= hVis || v >= vVis || tbCtrl[0]) begin
            return 4'h0;
        end
        line = tbCtrl[2] ? v : v / 2;
        lin = line * (hVis / 4) + h / 4;
        chip = tbCtrl[2] ? lin[15] : tbCtrl[1];
        b = chip ? gold1[lin & 32'h7FFF] : gold0[lin & 32'h7FFF];
        k = h % 4;
        if (tbCtrl[3]) begin
            pair = 2'(b >> (6 - 2 * k));
            return {pair[1], pair[1], pair[1], pair[0]};
        end
        return (k < 2) ? b[7:4] : b[3:0];
    endfunction

    // follow the syncs using the values just before the edge
    always @(posedge pixClk or negedge nReset) begin : trackBlk
        int nh;
        int nv;
        if (!nReset) begin
            posH <= 0;
            posV <= 0;
            lockedV <= 1'b0;
            expPix <= 4'h0;
            hPrev <= 1'b1;
            vPrev <= 1'b0;
            hLowLen <= 0;
            hPer <= 0;
            hPerValid <= 1'b0;
            vHighLen <= 0;
            vPer <= 0;
            vPerValid <= 1'b0;
        end else begin
            nh = (posH + 1) % hTotal;
            nv = (nh == 0) ? (posV + 1) % vTotal : posV;
            // first low sample of hsync sits at column hVis+hFront
            if (hPrev && !vidH) begin
                nh = hVis + hFront + 1;
            end
            // first high sample of vsync sits at column 0 of line vVis+vFront
            if (!vPrev && vidV) begin
                nh = 1;
                nv = vVis + vFront;
            end
            posH <= nh;
            posV <= nv;
            expPix <= pixelFor(nh, nv);
            lockedV <= lockedV || (!vPrev && vidV);
            hPrev <= vidH;
            vPrev <= vidV;
            hLowLen <= !vidH ? hLowLen + 1 : 0;
            hPer <= (hPrev && !vidH) ? 1 : hPer + 1;
            hPerValid <= hPerValid || (hPrev && !vidH);
            vHighLen <= vidV ? vHighLen + 1 : 0;
            vPer <= (!vPrev && vidV) ? 1 : vPer + 1;
            vPerValid <= vPerValid || (!vPrev && vidV);
            if (checkOn && lockedV) begin
                pixChecks <= pixChecks + 1;
            end
        end
    end

    pixMatch: assert property (@(posedge pixClk) disable iff (!nReset)
        (checkOn && lockedV) |-> vidOut == expPix)
        else begin
            errCount++;
            $display("Fail %0t vidOut expected %h got %h (h %0d v %0d)", $time,
                $sampled(expPix), $sampled(vidOut), $sampled(posH), $sampled(posV));
        end

    hWidth: assert property (@(posedge pixClk) disable iff (!nReset)
        $rose(vidH) |-> hLowLen == hSync)
        else begin
            errCount++;
            $display("Fail %0t vidH low width expected %0d got %0d", $time, hSync,
                $sampled(hLowLen));
        end

    hPeriod: assert property (@(posedge pixClk) disable iff (!nReset)
        ($fell(vidH) && hPerValid) |-> hPer == hTotal)
        else begin
            errCount++;
            $display("Fail %0t vidH period expected %0d got %0d", $time, hTotal,
                $sampled(hPer));
        end

    vWidth: assert property (@(posedge pixClk) disable iff (!nReset)
        $fell(vidV) |-> vHighLen == vSync * hTotal)
        else begin
            errCount++;
            $display("Fail %0t vidV high width expected %0d got %0d", $time,
                vSync * hTotal, $sampled(vHighLen));
        end

    vPeriod: assert property (@(posedge pixClk) disable iff (!nReset)
        ($rose(vidV) && vPerValid) |-> vPer == hTotal * vTotal)
        else begin
            errCount++;
            $display("Fail %0t vidV period expected %0d got %0d", $time,
                hTotal * vTotal, $sampled(vPer));
        end

    // register read shows the control bits with the top two bits set
    regBits: assert property (@(posedge pixClk) disable iff (!nReset)
        (!nCpuDSACK && cpuRnW && cpuAddr == ctrlAddr) |->
            (cpuDataOe && cpuDataOut[7:6] == 2'b11 && cpuDataOut[3:0] == tbCtrl))
        else begin
            errCount++;
            $display("Fail %0t cpuDataOut expected 11xx%b got %b", $time,
                $sampled(tbCtrl), $sampled(cpuDataOut));
        end

    regVBlank: assert property (@(posedge pixClk) disable iff (!nReset)
        (!nCpuDSACK && cpuRnW && cpuAddr == ctrlAddr && vidV) |-> cpuDataOut[5])
        else begin
            errCount++;
            $display("Fail %0t cpuDataOut[5] expected 1 got %b", $time,
                $sampled(cpuDataOut[5]));
        end

    // dropped vram read
    fillRead: assert property (@(posedge pixClk) disable iff (!nReset)
        (!nCpuDSACK && cpuRnW && cpuAddr != ctrlAddr) |->
            (cpuDataOe && cpuDataOut == 8'hFF))
        else begin
            errCount++;
            $display("Fail %0t cpuDataOut expected ff got %h", $time,
                $sampled(cpuDataOut));
        end

    // run limit
    always @(posedge pixClk) begin
        cycleCount++;
        if (cycleCount >= maxCycles) begin
            $display("Timeout, run stopped after %0d cycles", cycleCount);
            $display("Test failed");
            $finish;
        end
    end

    task randomByte(output logic [7:0] b);
        b = 8'h00;
        for (int i = 0; i < 8; i++) begin
            lfsrState = lfsrNext(lfsrState);
            b = {b[6:0], lfsrState[0]};
        end
    endtask

    // one cpu cycle with the strobes held until acknowledge
    task cpuAccess(input logic rnw, input logic [15:0] addr, input logic [7:0] data,
                   output logic [7:0] rdata);
        int waited;
        @(posedge pixClk);
        nCpuCE <= 1'b0;
        nCpuDS <= 1'b0;
        cpuRnW <= rnw;
        cpuAddr <= addr;
        cpuDataIn <= data;
        accessCount++;
        waited = 0;
        do begin
            @(posedge pixClk);
            waited++;
        end while (nCpuDSACK && waited < ackLimit);
        if (nCpuDSACK) begin
            errCount++;
            $display("Cpu access to %h was not acknowledged in time", addr);
        end else begin
            ackCount++;
        end
        rdata = cpuDataOut;
        nCpuCE <= 1'b1;
        nCpuDS <= 1'b1;
        if (!rnw && addr == ctrlAddr) begin
            tbCtrl = data[3:0];
        end else if (!rnw && addr[15]) begin
            gold1[addr[14:0]] = data;
        end else if (!rnw) begin
            gold0[addr[14:0]] = data;
        end
    endtask

    task writeByte(input logic [15:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        cpuAccess(1'b0, addr, data, unused);
    endtask

    task waitVsyncRise;
        logic was;
        was = vidV;
        @(posedge pixClk);
        while (!(vidV && !was)) begin
            was = vidV;
            @(posedge pixClk);
        end
    endtask

    // check one whole frame of output
    task checkFrame;
        waitVsyncRise();
        checkOn <= 1'b1;
        waitVsyncRise();
        checkOn <= 1'b0;
    endtask

    task compareMemory;
        for (int a = 0; a < 32768; a++) begin
            if (vramModel_i.mem0[a] !== gold0[a]) begin
                errCount++;
                $display("Fail %0t mem0[%h] expected %h got %h", $time, a[14:0],
                    gold0[a], vramModel_i.mem0[a]);
            end
            if (vramModel_i.mem1[a] !== gold1[a]) begin
                errCount++;
                $display("Fail %0t mem1[%h] expected %h got %h", $time, a[14:0],
                    gold1[a], vramModel_i.mem1[a]);
            end
        end
    endtask

    initial begin
        logic [7:0] b;
        logic [7:0] rd;
        nReset = 1'b0;
        nCpuCE = 1'b1;
        nCpuDS = 1'b1;
        cpuRnW = 1'b1;
        cpuAddr = 16'h0000;
        cpuDataIn = 8'h00;
        checkOn = 1'b0;
        tbCtrl = 4'h0;
        lfsrState = 32'haf3b9219;
        errCount = 0;
        pixChecks = 0;
        accessCount = 0;
        ackCount = 0;
        cycleCount = 0;
        for (int a = 0; a < 32768; a++) begin
            gold0[a] = fillByte(1'b0, a);
            gold1[a] = fillByte(1'b1, a);
        end
        repeat (3) @(posedge pixClk);
        nReset <= 1'b1;

        // register write and read back
        writeByte(ctrlAddr, 8'h0A);
        cpuAccess(1'b1, ctrlAddr, 8'h00, rd);

        // random fill of the linear area in chip 0 and the second buffer in chip 1
        for (int a = 0; a < 64; a++) begin
            randomByte(b);
            writeByte(16'(a), b);
        end
        for (int a = 0; a < 32; a++) begin
            randomByte(b);
            writeByte(16'h8000 | 16'(a), b);
        end

        // 4bpp in both buffers
        writeByte(ctrlAddr, 8'h00);
        checkFrame();
        writeByte(ctrlAddr, 8'h02);
        checkFrame();
        // vsync just rose so the status must show vertical blank
        cpuAccess(1'b1, ctrlAddr, 8'h00, rd);

        // 2bpp linear
        writeByte(ctrlAddr, 8'h0C);
        checkFrame();

        // blank over mode 3
        writeByte(ctrlAddr, 8'h0D);
        checkFrame();

        // writes and a dropped read inside active lines
        while (vidV) begin
            @(posedge pixClk);
        end
        repeat (vBack * hTotal + 6) @(posedge pixClk);
        for (int a = 0; a < 16; a++) begin
            randomByte(b);
            writeByte(16'h0040 + 16'(a), b);
        end
        cpuAccess(1'b1, 16'h0010, 8'h00, rd);
        repeat (4) @(posedge pixClk);

        compareMemory();
        if (pixChecks == 0) begin
            errCount++;
            $display("No visible pixels were checked");
        end
        $display("errors %0d, pixel checks %0d, cpu accesses %0d, acknowledged %0d",
            errCount, pixChecks, accessCount, ackCount);
        if (errCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
src/vidGenPkg.sv
src/scanTimer.sv
src/cpuBusFsm.sv
src/vramSequencer.sv
src/pixelShifter.sv
src/vidGen.sv
sim/vramModel.sv
sim/vidGenTb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module vidGenTb -f flist.f -o simv
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation returned status $simStatus"
    exit 1
fi

if grep -q "^Test completed successfully$" sim.log; then
    exit 0
fi
exit 1
